/* bench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH
`default_nettype none

// --------------------
// random data

// fibonacci LFSR with taps 32 22 2 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic cmd_pkg::data_t random_word();
    cmd_pkg::data_t w;
    w = '0;
    for (int i = 0; i < $bits(cmd_pkg::data_t); i++) begin
        w = {w[$bits(cmd_pkg::data_t)-2:0], lfsr_bit()};    // one step per bit
    end
    return w;
endfunction

// --------------------
// each decoder token is one strobe then one quiet cycle

task automatic send_token(input cmd_pkg::tok_kind_e tk, input logic [3:0] nib);
    token = '{done: 1'b1, kind: tk, nibble: nib};
    @(posedge clk);
    #1;
    token = '0;
    @(posedge clk);
    #1;
endtask

// most significant digit first
task automatic send_hex(input logic [31:0] value, input int digits);
    for (int i = digits - 1; i >= 0; i--) begin
        send_token(cmd_pkg::TOK_HEX, value[4*i +: 4]);
    end
endtask

task automatic send_line_end();
    send_token(cmd_pkg::TOK_CR, 4'h0);
    send_token(cmd_pkg::TOK_LF, 4'h0);
endtask

task automatic send_write(input cmd_pkg::addr_t addr, input cmd_pkg::data_t data);
    send_token(cmd_pkg::TOK_WRITE, 4'h0);
    send_token(cmd_pkg::TOK_SPACE, 4'h0);
    send_hex(32'(addr), 2);
    send_token(cmd_pkg::TOK_SPACE, 4'h0);
    send_hex(data, 8);
    send_line_end();
endtask

task automatic send_read(input cmd_pkg::addr_t addr);
    send_token(cmd_pkg::TOK_READ, 4'h0);
    send_token(cmd_pkg::TOK_SPACE, 4'h0);
    send_hex(32'(addr), 2);
    send_line_end();
endtask

// --------------------
// reply symbols

task automatic expect_symbol(input cmd_pkg::sym_kind_e kind, input logic [3:0] digit);
    int waited;
    waited = 0;
    while (reply.kind == cmd_pkg::SYM_NONE && waited < SYM_WAIT_LIMIT) begin
        @(posedge clk);
        #1;
        waited++;
    end
    assert (waited < SYM_WAIT_LIMIT)
        else abort_run("no reply symbol arrived within the timeout");
    assert (reply.kind == kind)
        else report_mismatch("reply_o.kind", 32'(reply.kind), 32'(kind));
    if (kind == cmd_pkg::SYM_DIGIT) begin
        assert (reply.digit == digit)
            else report_mismatch("reply_o.digit", 32'(reply.digit), 32'(digit));
    end
    @(posedge clk);    // step past this pulse
    #1;
endtask

task automatic expect_reply_end();
    expect_symbol(cmd_pkg::SYM_ENTER, 4'h0);
    expect_symbol(cmd_pkg::SYM_PROMPT, 4'h0);
endtask

task automatic expect_ok_reply();
    expect_symbol(cmd_pkg::SYM_O, 4'h0);
    expect_symbol(cmd_pkg::SYM_K, 4'h0);
    expect_reply_end();
endtask

task automatic expect_fail_reply();
    expect_symbol(cmd_pkg::SYM_F, 4'h0);
    expect_symbol(cmd_pkg::SYM_A, 4'h0);
    expect_symbol(cmd_pkg::SYM_I, 4'h0);
    expect_symbol(cmd_pkg::SYM_L, 4'h0);
    expect_reply_end();
endtask

task automatic expect_read_reply(input cmd_pkg::data_t word);
    cmd_pkg::data_t rest;
    rest = word;
    for (int i = 0; i < 8; i++) begin
        expect_symbol(cmd_pkg::SYM_DIGIT, rest[31:28]);
        rest = rest << 4;
    end
    expect_reply_end();
endtask

// --------------------
// register side checks

task automatic check_counts(input int exp_wr, input int exp_rd);
    assert (wr_count == exp_wr)
        else report_mismatch("reg_req_o.wr pulse count", 32'(wr_count), 32'(exp_wr));
    assert (rd_count == exp_rd)
        else report_mismatch("reg_req_o.rd pulse count", 32'(rd_count), 32'(exp_rd));
endtask

task automatic check_last_req(input logic wr, input cmd_pkg::addr_t addr,
                              input cmd_pkg::data_t data);
    assert (last_req.wr == wr)
        else report_mismatch("reg_req_o.wr", 32'(last_req.wr), 32'(wr));
    assert (last_req.rd == !wr)
        else report_mismatch("reg_req_o.rd", 32'(last_req.rd), 32'(!wr));
    assert (last_req.addr == addr)
        else report_mismatch("reg_req_o.addr", 32'(last_req.addr), 32'(addr));
    if (wr) begin    // read requests carry no data
        assert (last_req.data == data)
            else report_mismatch("reg_req_o.data", last_req.data, data);
    end
endtask

`default_nettype wire
`endif

/* bench/tb_uart_cmd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_ctrl;

    localparam int SYM_PERIOD     = cmd_pkg::SYMBOL_TICKS + 1;
    localparam int SYM_WAIT_LIMIT = 4 * SYM_PERIOD;    // several symbol times

    logic                 clk = 1'b0;
    logic                 rst;
    cmd_pkg::token_t      token;
    cmd_pkg::reg_rsp_t    reg_rsp = '0;
    cmd_pkg::reg_req_t    reg_req;
    cmd_pkg::reply_sym_t  reply;

    logic [31:0]          lfsr_state = 32'd76833;

    always #2 clk = ~clk;

    uart_cmd_ctrl u_dut (
        .clk       (clk),
        .rst       (rst),
        .token_i   (token),
        .reg_rsp_i (reg_rsp),
        .reg_req_o (reg_req),
        .reply_o   (reply)
    );

    // --------------------
    // failure reporting

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] time %0t ns: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
        $display("Simulation finished: FAIL");
        $fatal(1, "value mismatch on %s", sig);
    endtask

    task automatic abort_run(input string what);
        $display("time %0t ns: %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", what);
    endtask

    // --------------------
    // register model, four words, answers one cycle after the request

    cmd_pkg::data_t     regs [4];
    cmd_pkg::reg_req_t  req_prev = '0;
    cmd_pkg::reg_req_t  last_req = '0;
    int                 wr_count = 0;
    int                 rd_count = 0;

    always @(posedge clk) begin
        #1;
        reg_rsp = '0;
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] = {4{8'hd0 | 8'(i)}};       // fill pattern per word
            end
        end else if (req_prev.wr) begin
            regs[req_prev.addr[1:0]] = req_prev.data;
            reg_rsp.wr_done = 1'b1;
        end else if (req_prev.rd) begin
            reg_rsp.rdata   = regs[req_prev.addr[1:0]];
            reg_rsp.rd_done = 1'b1;
        end
        req_prev = reg_req;
        if (reg_req.wr || reg_req.rd) begin
            last_req = reg_req;
            wr_count += int'(reg_req.wr);
            rd_count += int'(reg_req.rd);
        end
    end

    // --------------------
    // symbol spacing tracker

    int unsigned sym_gap;       // cycles since the last pulse
    logic        mid_reply;     // last pulse was not a prompt

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            sym_gap   <= 0;
            mid_reply <= 1'b0;
        end else if (reply.kind != cmd_pkg::SYM_NONE) begin
            sym_gap   <= 1;
            mid_reply <= (reply.kind != cmd_pkg::SYM_PROMPT);
        end else begin
            sym_gap   <= sym_gap + 1;
        end
    end

    req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(reg_req.wr && reg_req.rd))
        else abort_run("reg_req_o.wr and reg_req_o.rd are high in the same cycle");

    req_quiet: assert property (@(posedge clk) disable iff (rst)
        !(reg_req.wr || reg_req.rd) |-> (reg_req.addr == '0 && reg_req.data == '0))
        else abort_run("reg_req_o carries address or data without a strobe");

    sym_spacing: assert property (@(posedge clk) disable iff (rst)
        (reply.kind != cmd_pkg::SYM_NONE && mid_reply) |-> (sym_gap == SYM_PERIOD))
        else abort_run("reply symbols within one reply are not SYMBOL_TICKS+1 cycles apart");

    // --------------------
    // stimulus

    initial begin
        cmd_pkg::data_t word_a;
        cmd_pkg::data_t word_b;
        cmd_pkg::data_t junk;

        rst   = 1'b1;
        token = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset reply, no requests
        expect_symbol(cmd_pkg::SYM_ENTER, 4'h0);
        expect_symbol(cmd_pkg::SYM_PROMPT, 4'h0);
        check_counts(0, 0);

        // write then read back address 1
        word_a = random_word();
        send_write(8'h01, word_a);
        expect_ok_reply();
        check_counts(1, 0);
        check_last_req(1'b1, 8'h01, word_a);
        send_read(8'h01);
        expect_read_reply(word_a);
        check_counts(1, 1);
        check_last_req(1'b0, 8'h01, '0);

        // addresses out of range
        junk = random_word();
        send_write(8'h00, junk);
        expect_fail_reply();
        send_write(8'h03, junk);
        expect_fail_reply();
        send_read(8'h00);
        expect_fail_reply();
        send_read(8'h03);
        expect_fail_reply();
        check_counts(1, 1);

        // no space after W, then a good write
        send_token(cmd_pkg::TOK_WRITE, 4'h0);
        send_hex(32'h01, 2);
        send_token(cmd_pkg::TOK_SPACE, 4'h0);
        send_hex(junk, 8);
        send_line_end();
        expect_fail_reply();
        check_counts(1, 1);
        word_b = random_word();
        send_write(8'h02, word_b);
        expect_ok_reply();
        check_counts(2, 1);
        check_last_req(1'b1, 8'h02, word_b);

        // bad character inside the data field, then a good read
        send_token(cmd_pkg::TOK_WRITE, 4'h0);
        send_token(cmd_pkg::TOK_SPACE, 4'h0);
        send_hex(32'h02, 2);
        send_token(cmd_pkg::TOK_SPACE, 4'h0);
        send_hex(junk >> 20, 3);
        send_token(cmd_pkg::TOK_BAD, 4'h0);
        send_hex(junk, 5);
        send_line_end();
        expect_fail_reply();
        check_counts(2, 1);
        send_read(8'h02);
        expect_read_reply(word_b);
        check_counts(2, 2);

        // extra data digit where CR belongs, address 1 must keep word_a
        send_token(cmd_pkg::TOK_WRITE, 4'h0);
        send_token(cmd_pkg::TOK_SPACE, 4'h0);
        send_hex(32'h01, 2);
        send_token(cmd_pkg::TOK_SPACE, 4'h0);
        send_hex(junk, 8);
        send_hex(32'h7, 1);
        send_line_end();
        expect_fail_reply();
        check_counts(2, 2);
        send_read(8'h01);
        expect_read_reply(word_a);
        check_counts(2, 3);

        $display("Simulation finished: PASS");
        $finish;
    end

    `include "tb_tasks.svh"

endmodule

`default_nettype wire

/* list.f */
+incdir+bench
logic/cmd_pkg.sv
logic/hex_field_collector.sv
logic/cmd_parser.sv
logic/reply_sequencer.sv
logic/uart_cmd_ctrl.sv
bench/tb_uart_cmd_ctrl.sv

/* logic/cmd_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cmd_pkg::token_t    token_i,
    output cmd_pkg::reg_req_t       reg_req_o,
    output logic                    fail_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GOT_WRITE,
        ST_GOT_READ,
        ST_ADDR,
        ST_DATA,
        ST_WAIT_CR,
        ST_WAIT_LF,
        ST_ERROR
    } ps_state_e;

    ps_state_e         state_q;
    ps_state_e         state_d;

    logic              wr_cmd_q;      // W seen at line start, else R
    logic              addr_bad_q;    // address outside ADDR_MIN..ADDR_MAX

    logic              tok_v;
    logic              tok_hex;
    logic              tok_lf;
    logic              cmd_ok;

    logic              fields_clear;
    logic              addr_shift;
    logic              data_shift;
    cmd_pkg::addr_t    addr_val;
    cmd_pkg::data_t    data_val;
    logic              addr_full;
    logic              data_full;

    assign tok_v   = token_i.done;
    assign tok_hex = tok_v && (token_i.kind == cmd_pkg::TOK_HEX);
    assign tok_lf  = tok_v && (token_i.kind == cmd_pkg::TOK_LF);

    // complete line with a good address
    assign cmd_ok = tok_lf && (state_q == ST_WAIT_LF) && !addr_bad_q;

    // --------------------
    // hex fields

    assign fields_clear = (state_q == ST_IDLE);
    assign addr_shift   = tok_hex && (state_q == ST_ADDR);
    assign data_shift   = tok_hex && (state_q == ST_DATA);

    hex_field_collector #(
        .field_t (cmd_pkg::addr_t)
    ) u_addr_field (
        .clk      (clk),
        .rst      (rst),
        .clear_i  (fields_clear),
        .shift_i  (addr_shift),
        .nibble_i (token_i.nibble),
        .value_o  (addr_val),
        .full_o   (addr_full)
    );

    hex_field_collector #(
        .field_t (cmd_pkg::data_t)
    ) u_data_field (
        .clk      (clk),
        .rst      (rst),
        .clear_i  (fields_clear),
        .shift_i  (data_shift),
        .nibble_i (token_i.nibble),
        .value_o  (data_val),
        .full_o   (data_full)
    );

    // --------------------
    // grammar FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (tok_v) begin
                    if (token_i.kind == cmd_pkg::TOK_WRITE) begin
                        state_d = ST_GOT_WRITE;
                    end else if (token_i.kind == cmd_pkg::TOK_READ) begin
                        state_d = ST_GOT_READ;
                    end else begin
                        state_d = ST_ERROR;
                    end
                end
            end
            ST_GOT_WRITE, ST_GOT_READ: begin
                if (tok_v) begin
                    state_d = (token_i.kind == cmd_pkg::TOK_SPACE) ? ST_ADDR : ST_ERROR;
                end
            end
            ST_ADDR: begin
                if (tok_v) begin
                    if (tok_hex && !addr_full) begin
                        state_d = ST_ADDR;
                    end else if (addr_full && wr_cmd_q
                                 && token_i.kind == cmd_pkg::TOK_SPACE) begin
                        state_d = ST_DATA;
                    end else if (addr_full && !wr_cmd_q
                                 && token_i.kind == cmd_pkg::TOK_CR) begin
                        state_d = ST_WAIT_LF;
                    end else begin
                        state_d = ST_ERROR;
                    end
                end else if (addr_full && !wr_cmd_q) begin
                    state_d = ST_WAIT_CR;       // read line only needs CR now
                end
            end
            ST_DATA: begin
                if (tok_v) begin
                    if (tok_hex && !data_full) begin
                        state_d = ST_DATA;
                    end else if (data_full && token_i.kind == cmd_pkg::TOK_CR) begin
                        state_d = ST_WAIT_LF;
                    end else begin
                        state_d = ST_ERROR;     // e.g. a ninth digit
                    end
                end else if (data_full) begin
                    state_d = ST_WAIT_CR;
                end
            end
            ST_WAIT_CR: begin
                if (tok_v) begin
                    state_d = (token_i.kind == cmd_pkg::TOK_CR) ? ST_WAIT_LF : ST_ERROR;
                end
            end
            ST_WAIT_LF: begin
                if (tok_v) begin
                    state_d = ST_ERROR;
                end
            end
            default: begin
                state_d = ST_ERROR;             // error holds until LF
            end
        endcase

        // LF always closes the line
        if (tok_lf) begin
            state_d = ST_IDLE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // command letter, latched when the line starts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_cmd_q <= 1'b0;
        end else if (state_q == ST_IDLE && tok_v) begin
            wr_cmd_q <= (token_i.kind == cmd_pkg::TOK_WRITE);
        end
    end

    // address range check once both digits are in
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_bad_q <= 1'b0;
        end else if (state_q == ST_IDLE) begin
            addr_bad_q <= 1'b0;
        end else if (addr_full) begin
            addr_bad_q <= (addr_val < cmd_pkg::ADDR_MIN) || (addr_val > cmd_pkg::ADDR_MAX);
        end
    end

    // --------------------
    // request / fail strobes, one cycle after LF

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_req_o <= '0;
            fail_o    <= 1'b0;
        end else begin
            reg_req_o <= '0;                    // addr and data zero between strobes
            fail_o    <= tok_lf && !cmd_ok;
            if (cmd_ok) begin
                reg_req_o.wr   <= wr_cmd_q;
                reg_req_o.rd   <= !wr_cmd_q;
                reg_req_o.addr <= addr_val;
                reg_req_o.data <= data_val;     // still zero on a read line
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

    // --------------------
    // decoder side

    localparam int NIBBLE_W = 4;              // one hex digit

    typedef enum logic [2:0] {
        TOK_HEX,
        TOK_WRITE,                            // 'W'
        TOK_READ,                             // 'R'
        TOK_SPACE,
        TOK_CR,
        TOK_LF,
        TOK_BAD                               // anything the decoder does not know
    } tok_kind_e;

    typedef struct packed {
        logic                done;            // token strobe
        tok_kind_e           kind;
        logic [NIBBLE_W-1:0] nibble;          // only meaningful for TOK_HEX
    } token_t;

    // --------------------
    // register file side

    typedef logic [7:0]  addr_t;
    typedef logic [31:0] data_t;

    localparam addr_t ADDR_MIN = 8'd1;
    localparam addr_t ADDR_MAX = 8'd2;

    typedef struct packed {
        logic  wr;
        logic  rd;
        addr_t addr;
        data_t data;
    } reg_req_t;

    typedef struct packed {
        logic  wr_done;
        logic  rd_done;
        data_t rdata;                         // valid with rd_done
    } reg_rsp_t;

    // --------------------
    // encoder side

    typedef enum logic [3:0] {
        SYM_NONE,
        SYM_O,
        SYM_K,
        SYM_F,
        SYM_A,
        SYM_I,
        SYM_L,
        SYM_DIGIT,
        SYM_ENTER,
        SYM_PROMPT
    } sym_kind_e;

    typedef struct packed {
        sym_kind_e           kind;
        logic [NIBBLE_W-1:0] digit;           // used with SYM_DIGIT
    } reply_sym_t;

    localparam reply_sym_t REPLY_NONE = '{kind: SYM_NONE, digit: '0};

    // symbol pacing, one symbol every SYMBOL_TICKS+1 clocks
    localparam int SYMBOL_TICKS = 4780;
    localparam int SYM_TIMER_W  = $clog2(SYMBOL_TICKS + 1);

    typedef logic [SYM_TIMER_W-1:0] sym_timer_t;
    typedef logic [3:0]             sym_idx_t;

    localparam sym_timer_t SYM_TIMER_LAST = sym_timer_t'(SYMBOL_TICKS);
    localparam sym_idx_t   DATA_DIGITS    = sym_idx_t'($bits(data_t) / NIBBLE_W);

endpackage

`default_nettype wire

/* logic/hex_field_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module hex_field_collector #(
    parameter type field_t = logic [7:0]
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          clear_i,   // zero value and count
    input  wire                          shift_i,   // take nibble_i
    input  wire [cmd_pkg::NIBBLE_W-1:0]  nibble_i,
    output field_t                       value_o,
    output logic                         full_o
);

    localparam int FIELD_W = $bits(field_t);
    localparam int DIGITS  = FIELD_W / cmd_pkg::NIBBLE_W;
    localparam int CNT_W   = $clog2(DIGITS + 1);

    logic [FIELD_W-1:0] value_q;
    logic [CNT_W-1:0]   cnt_q;

    assign full_o  = (cnt_q == CNT_W'(DIGITS));
    assign value_o = field_t'(value_q);

    // digit counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;
        end else if (shift_i && !full_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // new digit enters at the low end, first digit ends up most significant
    always_ff @(posedge clk) begin
        if (clear_i) begin
            value_q <= '0;
        end else if (shift_i && !full_o) begin
            value_q <= {value_q[FIELD_W-cmd_pkg::NIBBLE_W-1:0], nibble_i};
        end
    end

endmodule

`default_nettype wire

/* logic/reply_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module reply_sequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     fail_i,
    input  wire cmd_pkg::reg_rsp_t  reg_rsp_i,
    output cmd_pkg::reply_sym_t     reply_o
);

    typedef enum logic [2:0] {
        ST_RESET_REPLY,
        ST_IDLE,
        ST_OK_REPLY,
        ST_READ_REPLY,
        ST_FAIL_REPLY
    } rs_state_e;

    rs_state_e               state_q;
    logic                    boot_q;       // high in the first cycle after reset

    cmd_pkg::sym_timer_t     timer_q;
    cmd_pkg::sym_idx_t       sym_idx_q;    // symbols sent in this reply
    cmd_pkg::data_t          rd_buf_q;

    logic                    sym_tick;
    logic                    last_sym;
    cmd_pkg::sym_idx_t       body_len;     // symbols before enter
    cmd_pkg::sym_idx_t       prompt_idx;
    cmd_pkg::reply_sym_t     sym_d;

    assign sym_tick = (state_q != ST_IDLE) && (timer_q == cmd_pkg::SYM_TIMER_LAST);

    // --------------------
    // symbol select

    always_comb begin
        case (state_q)
            ST_OK_REPLY:   body_len = cmd_pkg::sym_idx_t'(2);
            ST_READ_REPLY: body_len = cmd_pkg::DATA_DIGITS;
            ST_FAIL_REPLY: body_len = cmd_pkg::sym_idx_t'(4);
            default:       body_len = '0;        // reset reply is enter, prompt only
        endcase
    end

    assign prompt_idx = body_len + 1'b1;
    assign last_sym   = (sym_idx_q == prompt_idx);

    always_comb begin
        sym_d = cmd_pkg::REPLY_NONE;
        if (sym_idx_q == body_len) begin
            sym_d.kind = cmd_pkg::SYM_ENTER;
        end else if (last_sym) begin
            sym_d.kind = cmd_pkg::SYM_PROMPT;
        end else begin
            case (state_q)
                ST_OK_REPLY: begin
                    sym_d.kind = (sym_idx_q == '0) ? cmd_pkg::SYM_O : cmd_pkg::SYM_K;
                end
                ST_READ_REPLY: begin
                    sym_d.kind  = cmd_pkg::SYM_DIGIT;
                    sym_d.digit = rd_buf_q[$bits(cmd_pkg::data_t)-1 -: cmd_pkg::NIBBLE_W];
                end
                ST_FAIL_REPLY: begin
                    case (sym_idx_q[1:0])
                        2'd0:    sym_d.kind = cmd_pkg::SYM_F;
                        2'd1:    sym_d.kind = cmd_pkg::SYM_A;
                        2'd2:    sym_d.kind = cmd_pkg::SYM_I;
                        default: sym_d.kind = cmd_pkg::SYM_L;
                    endcase
                end
                default: begin
                    sym_d = cmd_pkg::REPLY_NONE;
                end
            endcase
        end
    end

    // --------------------
    // reply FSM

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
            boot_q  <= 1'b1;
        end else begin
            boot_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (boot_q) begin
                        state_q <= ST_RESET_REPLY;
                    end else if (fail_i) begin
                        state_q <= ST_FAIL_REPLY;
                    end else if (reg_rsp_i.wr_done) begin
                        state_q <= ST_OK_REPLY;
                    end else if (reg_rsp_i.rd_done) begin
                        state_q <= ST_READ_REPLY;
                    end
                end
                default: begin
                    if (sym_tick && last_sym) begin
                        state_q <= ST_IDLE;  // triggers while busy were dropped
                    end
                end
            endcase
        end
    end

    // timer starts at 1 so the first symbol lands SYMBOL_TICKS+1 after the trigger
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer_q   <= '0;
            sym_idx_q <= '0;
        end else if (state_q == ST_IDLE) begin
            timer_q   <= cmd_pkg::sym_timer_t'(1);
            sym_idx_q <= '0;
        end else if (sym_tick) begin
            timer_q   <= '0;
            sym_idx_q <= last_sym ? '0 : sym_idx_q + 1'b1;
        end else begin
            timer_q   <= timer_q + 1'b1;
        end
    end

    // read data, top nibble goes out first
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && reg_rsp_i.rd_done) begin
            rd_buf_q <= reg_rsp_i.rdata;
        end else if (sym_tick && state_q == ST_READ_REPLY) begin
            rd_buf_q <= rd_buf_q << cmd_pkg::NIBBLE_W;
        end
    end

    // one-cycle symbol pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reply_o <= cmd_pkg::REPLY_NONE;
        end else if (sym_tick) begin
            reply_o <= sym_d;
        end else begin
            reply_o <= cmd_pkg::REPLY_NONE;
        end
    end

endmodule

`default_nettype wire

/* logic/uart_cmd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_ctrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cmd_pkg::token_t    token_i,      // from the character decoder
    input  wire cmd_pkg::reg_rsp_t  reg_rsp_i,    // from the register file
    output cmd_pkg::reg_req_t       reg_req_o,    // to the register file
    output cmd_pkg::reply_sym_t     reply_o       // to the encoder
);

    logic cmd_fail;    // bad line, parser to reply

    // --------------------
    // command side

    cmd_parser u_parser (
        .clk       (clk),
        .rst       (rst),
        .token_i   (token_i),
        .reg_req_o (reg_req_o),
        .fail_o    (cmd_fail)
    );

    // --------------------
    // reply side

    reply_sequencer u_reply (
        .clk       (clk),
        .rst       (rst),
        .fail_i    (cmd_fail),
        .reg_rsp_i (reg_rsp_i),
        .reply_o   (reply_o)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_uart_cmd_ctrl -f list.f -o tb_uart_cmd_ctrl &&
./obj_dir/tb_uart_cmd_ctrl ||
{ echo "simulation build or run failed"; exit 1; }
